/* Makefile */
TOP := tb_csr_top

.PHONY: all compile run clean

all: run

# Testbench and RTL into one executable
compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f build.f -o V$(TOP)

# Exit status is nonzero when the testbench stops on $$fatal
run: compile
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

/* build.f */
+incdir+tests
design/csr_pkg.sv
design/dma_pkg.sv
design/csr_bus_if.sv
design/csr_decoder.sv
design/dma_ctrl_regs.sv
design/irq_regs.sv
design/fofb_status_regs.sv
design/bmd_csr_top.sv
tests/tb_csr_top.sv

/* design/bmd_csr_top.sv */
`default_nettype none

module bmd_csr_top #(
    parameter logic [7:0]  FPGA_FAMILY    = 8'h14,
    parameter logic [3:0]  INTERFACE_TYPE = 4'h2,
    parameter logic [15:0] VERSION_NUMBER = 16'h0100
) (
    input  logic                              clk,
    input  logic                              init_rst_o,
    input  csr_pkg::csr_addr_t                a_i,
    input  logic                              wr_en_i,
    input  csr_pkg::csr_word_t                wr_d_i,
    output csr_pkg::csr_word_t                rd_d_o,
    output logic                              initiator_rst_o,
    output logic                              mwr_start_o,
    output logic                              mwr_stop_o,
    output logic                              mwr_relaxed_order_o,
    output logic                              mwr_nosnoop_o,
    output logic                              mwr_int_dis_o,
    output csr_pkg::csr_word_t                mwr_addr_o,
    output logic [dma_pkg::DMA_LEN_W-1:0]     mwr_len_o,
    output logic [dma_pkg::DMA_TC_W-1:0]      mwr_tlp_tc_o,
    output logic                              mwr_64b_en_o,
    output logic                              mwr_phant_func_dis1_o,
    output logic [dma_pkg::DMA_UPADDR_W-1:0]  mwr_up_addr_o,
    output logic [dma_pkg::DMA_COUNT_W-1:0]   mwr_count_o,
    output logic [dma_pkg::DMA_PATTERN_W-1:0] mwr_data_o,
    output logic                              next_wdma_valid_o,
    input  logic [7:0]                        cfg_interrupt_do_i,
    input  logic [2:0]                        cfg_interrupt_mmenable_i,
    input  logic                              cfg_interrupt_msienable_i,
    output logic [7:0]                        cfg_interrupt_di_o,
    output logic                              cfg_interrupt_legacyclr_o,
    output csr_pkg::csr_word_t                fai_cfg_val_o,
    input  logic [15:0]                       wdma_buf_ptr_i,
    input  logic [3:0]                        wdma_status_i,
    input  logic                              fofb_rxlink_up_i,
    input  logic                              fofb_cc_timeout_i,
    input  logic [9:0]                        fofb_rxlink_partner_i,
    input  logic [15:0]                       harderror_cnt_i,
    input  logic [15:0]                       softerror_cnt_i,
    input  logic [15:0]                       frameerror_cnt_i
);
    import dma_pkg::*;

    dma_ctrl_t mwr_ctrl;

    csr_bus_if dma_bus ();
    csr_bus_if irq_bus ();
    csr_bus_if fofb_bus ();

    // Flatten register 3 for the write engine
    assign mwr_len_o             = mwr_ctrl.len;
    assign mwr_tlp_tc_o          = mwr_ctrl.tc;
    assign mwr_64b_en_o          = mwr_ctrl.en_64b;
    assign mwr_phant_func_dis1_o = mwr_ctrl.phant_func_dis;
    assign mwr_up_addr_o         = mwr_ctrl.up_addr;

    csr_decoder decoder_i (
        .clk        (clk),
        .init_rst_o (init_rst_o),
        .a_i        (a_i),
        .wr_en_i    (wr_en_i),
        .wr_d_i     (wr_d_i),
        .rd_d_o     (rd_d_o),
        .dma_bus    (dma_bus),
        .irq_bus    (irq_bus),
        .fofb_bus   (fofb_bus)
    );

    dma_ctrl_regs #(
        .FPGA_FAMILY    (FPGA_FAMILY),
        .INTERFACE_TYPE (INTERFACE_TYPE),
        .VERSION_NUMBER (VERSION_NUMBER)
    ) dma_regs_i (
        .clk                 (clk),
        .init_rst_o          (init_rst_o),
        .bus                 (dma_bus),
        .initiator_rst_o     (initiator_rst_o),
        .mwr_start_o         (mwr_start_o),
        .mwr_stop_o          (mwr_stop_o),
        .mwr_relaxed_order_o (mwr_relaxed_order_o),
        .mwr_nosnoop_o       (mwr_nosnoop_o),
        .mwr_int_dis_o       (mwr_int_dis_o),
        .mwr_addr_o          (mwr_addr_o),
        .mwr_ctrl_o          (mwr_ctrl),
        .mwr_count_o         (mwr_count_o),
        .mwr_data_o          (mwr_data_o),
        .next_wdma_valid_o   (next_wdma_valid_o)
    );

    irq_regs irq_regs_i (
        .clk                       (clk),
        .init_rst_o                (init_rst_o),
        .bus                       (irq_bus),
        .cfg_interrupt_do_i        (cfg_interrupt_do_i),
        .cfg_interrupt_mmenable_i  (cfg_interrupt_mmenable_i),
        .cfg_interrupt_msienable_i (cfg_interrupt_msienable_i),
        .cfg_interrupt_di_o        (cfg_interrupt_di_o),
        .cfg_interrupt_legacyclr_o (cfg_interrupt_legacyclr_o)
    );

    fofb_status_regs fofb_regs_i (
        .clk                   (clk),
        .init_rst_o            (init_rst_o),
        .bus                   (fofb_bus),
        .fai_cfg_val_o         (fai_cfg_val_o),
        .wdma_buf_ptr_i        (wdma_buf_ptr_i),
        .wdma_status_i         (wdma_status_i),
        .fofb_rxlink_up_i      (fofb_rxlink_up_i),
        .fofb_cc_timeout_i     (fofb_cc_timeout_i),
        .fofb_rxlink_partner_i (fofb_rxlink_partner_i),
        .harderror_cnt_i       (harderror_cnt_i),
        .softerror_cnt_i       (softerror_cnt_i),
        .frameerror_cnt_i      (frameerror_cnt_i)
    );

endmodule

`default_nettype wire

/* design/csr_bus_if.sv */
`default_nettype none

// One register block's view of the host port
interface csr_bus_if;
    import csr_pkg::*;

    logic        sel;      // Index falls inside this block
    csr_offset_t offset;   // Index minus block base
    logic        wr_en;    // Raw host strobe, qualified by sel in the block
    csr_word_t   wr_data;
    csr_word_t   rd_data;  // Combinational from offset

    modport decoder (
        output sel,
        output offset,
        output wr_en,
        output wr_data,
        input  rd_data
    );

    modport regs (
        input  sel,
        input  offset,
        input  wr_en,
        input  wr_data,
        output rd_data
    );

endinterface

`default_nettype wire

/* design/csr_decoder.sv */
`default_nettype none

module csr_decoder (
    input  logic               clk,
    input  logic               init_rst_o,
    input  csr_pkg::csr_addr_t a_i,
    input  logic               wr_en_i,
    input  csr_pkg::csr_word_t wr_d_i,
    output csr_pkg::csr_word_t rd_d_o,
    csr_bus_if.decoder         dma_bus,
    csr_bus_if.decoder         irq_bus,
    csr_bus_if.decoder         fofb_bus
);
    import csr_pkg::*;

    csr_block_e blk;

    // Index below a base wraps far past the block size
    always_comb begin
        if (csr_addr_t'(a_i - CSR_DMA_BASE) < CSR_DMA_WORDS)
            blk = CSR_BLK_DMA;
        else if (csr_addr_t'(a_i - CSR_IRQ_BASE) < CSR_IRQ_WORDS)
            blk = CSR_BLK_IRQ;
        else if (csr_addr_t'(a_i - CSR_FOFB_BASE) < CSR_FOFB_WORDS)
            blk = CSR_BLK_FOFB;
        else
            blk = CSR_BLK_NONE;
    end

    assign dma_bus.sel  = (blk == CSR_BLK_DMA);
    assign irq_bus.sel  = (blk == CSR_BLK_IRQ);
    assign fofb_bus.sel = (blk == CSR_BLK_FOFB);

    // Only the low bits survive since no block exceeds eight words
    assign dma_bus.offset  = csr_offset_t'(a_i - CSR_DMA_BASE);
    assign irq_bus.offset  = csr_offset_t'(a_i - CSR_IRQ_BASE);
    assign fofb_bus.offset = csr_offset_t'(a_i - CSR_FOFB_BASE);

    assign dma_bus.wr_en  = wr_en_i;
    assign irq_bus.wr_en  = wr_en_i;
    assign fofb_bus.wr_en = wr_en_i;

    assign dma_bus.wr_data  = wr_d_i;
    assign irq_bus.wr_data  = wr_d_i;
    assign fofb_bus.wr_data = wr_d_i;

    // One cycle read latency
    always_ff @(posedge clk) begin
        if (init_rst_o) begin
            rd_d_o <= '0;
        end else begin
            case (blk)
                CSR_BLK_DMA:  rd_d_o <= dma_bus.rd_data;
                CSR_BLK_IRQ:  rd_d_o <= irq_bus.rd_data;
                CSR_BLK_FOFB: rd_d_o <= fofb_bus.rd_data;
                default:      rd_d_o <= '0;  // Unmapped index
            endcase
        end
    end

    a_one_sel: assert property (@(posedge clk)
        $onehot0({dma_bus.sel, irq_bus.sel, fofb_bus.sel}));

endmodule

`default_nettype wire

/* design/csr_pkg.sv */
`default_nettype none

package csr_pkg;

    typedef logic [6:0]  csr_addr_t;    // Word index from the host
    typedef logic [31:0] csr_word_t;
    typedef logic [2:0]  csr_offset_t;  // Word offset inside one block

    // Block placement in the word index space
    localparam csr_addr_t CSR_DMA_BASE   = 7'd0;
    localparam csr_addr_t CSR_DMA_WORDS  = 7'd6;
    localparam csr_addr_t CSR_IRQ_BASE   = 7'd18;
    localparam csr_addr_t CSR_IRQ_WORDS  = 7'd1;
    localparam csr_addr_t CSR_FOFB_BASE  = 7'd32;
    localparam csr_addr_t CSR_FOFB_WORDS = 7'd6;

    typedef enum logic [1:0] {
        CSR_BLK_DMA,
        CSR_BLK_IRQ,
        CSR_BLK_FOFB,
        CSR_BLK_NONE
    } csr_block_e;

    // Offsets in the DMA block
    localparam csr_offset_t CSR_OFF_ID       = 3'd0;
    localparam csr_offset_t CSR_OFF_WCTRL    = 3'd1;
    localparam csr_offset_t CSR_OFF_WADDR    = 3'd2;
    localparam csr_offset_t CSR_OFF_WLEN     = 3'd3;
    localparam csr_offset_t CSR_OFF_WCOUNT   = 3'd4;
    localparam csr_offset_t CSR_OFF_WPATTERN = 3'd5;

    localparam csr_offset_t CSR_OFF_IRQ = 3'd0;

    // Offsets in the FOFB block
    localparam csr_offset_t CSR_OFF_CC_CFG     = 3'd0;
    localparam csr_offset_t CSR_OFF_BUF_STATUS = 3'd1;
    localparam csr_offset_t CSR_OFF_LINK       = 3'd2;
    localparam csr_offset_t CSR_OFF_FRAME_ERR  = 3'd3;
    localparam csr_offset_t CSR_OFF_SOFT_ERR   = 3'd4;
    localparam csr_offset_t CSR_OFF_HARD_ERR   = 3'd5;

endpackage

`default_nettype wire

/* design/dma_ctrl_regs.sv */
`default_nettype none

module dma_ctrl_regs #(
    parameter logic [7:0]  FPGA_FAMILY    = 8'h14,
    parameter logic [3:0]  INTERFACE_TYPE = 4'h2,
    parameter logic [15:0] VERSION_NUMBER = 16'h0100
) (
    input  logic                              clk,
    input  logic                              init_rst_o,
    csr_bus_if.regs                           bus,
    output logic                              initiator_rst_o,
    output logic                              mwr_start_o,
    output logic                              mwr_stop_o,
    output logic                              mwr_relaxed_order_o,
    output logic                              mwr_nosnoop_o,
    output logic                              mwr_int_dis_o,
    output csr_pkg::csr_word_t                mwr_addr_o,
    output dma_pkg::dma_ctrl_t                mwr_ctrl_o,
    output logic [dma_pkg::DMA_COUNT_W-1:0]   mwr_count_o,
    output logic [dma_pkg::DMA_PATTERN_W-1:0] mwr_data_o,
    output logic                              next_wdma_valid_o
);
    import csr_pkg::*;
    import dma_pkg::*;

    logic wr_hit;
    logic addr_pend_lo;  // R2 written since last descriptor
    logic addr_pend_hi;  // R3 written since last descriptor

    assign wr_hit            = bus.sel && bus.wr_en;
    assign next_wdma_valid_o = addr_pend_lo && addr_pend_hi;

    always_ff @(posedge clk) begin
        if (init_rst_o) begin
            initiator_rst_o     <= 1'b0;
            mwr_start_o         <= 1'b0;
            mwr_stop_o          <= 1'b0;
            mwr_relaxed_order_o <= 1'b0;
            mwr_nosnoop_o       <= 1'b0;
            mwr_int_dis_o       <= 1'b0;
            mwr_addr_o          <= '0;
            mwr_ctrl_o          <= '0;
            mwr_count_o         <= '0;
            mwr_data_o          <= '0;
            addr_pend_lo        <= 1'b0;
            addr_pend_hi        <= 1'b0;
        end else begin
            mwr_start_o <= 1'b0;  // Pulses by default
            mwr_stop_o  <= 1'b0;

            // Descriptor complete once both halves have landed, in any order
            if (next_wdma_valid_o) begin
                addr_pend_lo <= 1'b0;
                addr_pend_hi <= 1'b0;
            end else if (wr_hit && bus.offset == CSR_OFF_WADDR) begin
                addr_pend_lo <= 1'b1;
            end else if (wr_hit && bus.offset == CSR_OFF_WLEN) begin
                addr_pend_hi <= 1'b1;
            end

            if (wr_hit) begin
                case (bus.offset)
                    CSR_OFF_ID: initiator_rst_o <= bus.wr_data[0];
                    CSR_OFF_WCTRL: begin
                        // No engine kick while the initiator is held in reset
                        mwr_start_o         <= bus.wr_data[0] && !initiator_rst_o;
                        mwr_stop_o          <= bus.wr_data[1] && !initiator_rst_o;
                        mwr_relaxed_order_o <= bus.wr_data[5];
                        mwr_nosnoop_o       <= bus.wr_data[6];
                        mwr_int_dis_o       <= bus.wr_data[7];
                    end
                    CSR_OFF_WADDR: mwr_addr_o <= bus.wr_data;
                    CSR_OFF_WLEN: begin
                        mwr_ctrl_o.len            <= bus.wr_data[DMA_LEN_W-1:0];
                        mwr_ctrl_o.tc             <= bus.wr_data[16 +: DMA_TC_W];
                        mwr_ctrl_o.en_64b         <= bus.wr_data[19];
                        mwr_ctrl_o.phant_func_dis <= bus.wr_data[20];
                        mwr_ctrl_o.up_addr        <= bus.wr_data[31 -: DMA_UPADDR_W];
                    end
                    CSR_OFF_WCOUNT:   mwr_count_o <= bus.wr_data[DMA_COUNT_W-1:0];
                    CSR_OFF_WPATTERN: mwr_data_o  <= bus.wr_data[DMA_PATTERN_W-1:0];
                    default: ;
                endcase
            end
        end
    end

    always_comb begin
        case (bus.offset)
            CSR_OFF_ID:       bus.rd_data = {FPGA_FAMILY, 4'h0, INTERFACE_TYPE, VERSION_NUMBER};
            CSR_OFF_WCTRL:    bus.rd_data = {24'h0, mwr_int_dis_o, mwr_nosnoop_o,
                                             mwr_relaxed_order_o, 5'h0};
            CSR_OFF_WADDR:    bus.rd_data = mwr_addr_o;
            CSR_OFF_WLEN:     bus.rd_data = {mwr_ctrl_o.up_addr, 3'h0,
                                             mwr_ctrl_o.phant_func_dis, mwr_ctrl_o.en_64b,
                                             mwr_ctrl_o.tc, 6'h0, mwr_ctrl_o.len};
            CSR_OFF_WCOUNT:   bus.rd_data = {16'h0, mwr_count_o};
            CSR_OFF_WPATTERN: bus.rd_data = {16'h0, mwr_data_o};
            default:          bus.rd_data = '0;
        endcase
    end

    // Descriptor strobe must not stretch, the engine counts it
    a_valid_single: assert property (@(posedge clk) disable iff (init_rst_o)
        next_wdma_valid_o |=> !next_wdma_valid_o);

    a_no_kick_in_rst: assert property (@(posedge clk) disable iff (init_rst_o)
        initiator_rst_o |-> !mwr_start_o && !mwr_stop_o);

endmodule

`default_nettype wire

/* design/dma_pkg.sv */
`default_nettype none

package dma_pkg;

    localparam int DMA_LEN_W     = 10;  // Dwords per write TLP
    localparam int DMA_TC_W      = 3;
    localparam int DMA_COUNT_W   = 16;
    localparam int DMA_PATTERN_W = 16;
    localparam int DMA_UPADDR_W  = 8;   // Address bits [39:32] for 64-bit writes

    // Register 3 fields, as handed to the write engine
    typedef struct packed {
        logic [DMA_UPADDR_W-1:0] up_addr;
        logic                    phant_func_dis;
        logic                    en_64b;
        logic [DMA_TC_W-1:0]     tc;
        logic [DMA_LEN_W-1:0]    len;
    } dma_ctrl_t;

endpackage

`default_nettype wire

/* design/fofb_status_regs.sv */
`default_nettype none

module fofb_status_regs (
    input  logic               clk,
    input  logic               init_rst_o,
    csr_bus_if.regs            bus,
    output csr_pkg::csr_word_t fai_cfg_val_o,
    input  logic [15:0]        wdma_buf_ptr_i,
    input  logic [3:0]         wdma_status_i,
    input  logic               fofb_rxlink_up_i,
    input  logic               fofb_cc_timeout_i,
    input  logic [9:0]         fofb_rxlink_partner_i,
    input  logic [15:0]        harderror_cnt_i,
    input  logic [15:0]        softerror_cnt_i,
    input  logic [15:0]        frameerror_cnt_i
);
    import csr_pkg::*;

    logic cfg_wr;

    assign cfg_wr = bus.sel && bus.wr_en && bus.offset == CSR_OFF_CC_CFG;

    // Communication controller configuration word
    always_ff @(posedge clk) begin
        if (init_rst_o)
            fai_cfg_val_o <= '0;
        else if (cfg_wr)
            fai_cfg_val_o <= bus.wr_data;
    end

    always_comb begin
        case (bus.offset)
            CSR_OFF_CC_CFG:     bus.rd_data = fai_cfg_val_o;
            CSR_OFF_BUF_STATUS: bus.rd_data = {8'h0, wdma_buf_ptr_i, 4'h0, wdma_status_i};
            CSR_OFF_LINK:       bus.rd_data = {14'h0, fofb_rxlink_partner_i, 6'h0,
                                               fofb_cc_timeout_i, fofb_rxlink_up_i};
            CSR_OFF_FRAME_ERR:  bus.rd_data = {16'h0, frameerror_cnt_i};
            CSR_OFF_SOFT_ERR:   bus.rd_data = {16'h0, softerror_cnt_i};
            CSR_OFF_HARD_ERR:   bus.rd_data = {16'h0, harderror_cnt_i};
            default:            bus.rd_data = '0;
        endcase
    end

    // Host writes are the only source, a change coming out of reset is allowed
    a_cfg_from_write: assert property (@(posedge clk) disable iff (init_rst_o)
        !$stable(fai_cfg_val_o) |-> $past(cfg_wr) || $past(init_rst_o));

endmodule

`default_nettype wire

/* design/irq_regs.sv */
`default_nettype none

module irq_regs (
    input  logic       clk,
    input  logic       init_rst_o,
    csr_bus_if.regs    bus,
    input  logic [7:0] cfg_interrupt_do_i,
    input  logic [2:0] cfg_interrupt_mmenable_i,
    input  logic       cfg_interrupt_msienable_i,
    output logic [7:0] cfg_interrupt_di_o,
    output logic       cfg_interrupt_legacyclr_o
);
    import csr_pkg::*;

    logic wr_hit;

    assign wr_hit = bus.sel && bus.wr_en && bus.offset == CSR_OFF_IRQ;

    always_ff @(posedge clk) begin
        if (init_rst_o) begin
            cfg_interrupt_di_o        <= '0;
            cfg_interrupt_legacyclr_o <= 1'b0;
        end else if (wr_hit) begin
            cfg_interrupt_di_o        <= bus.wr_data[7:0];  // Vector for the next MSI
            cfg_interrupt_legacyclr_o <= bus.wr_data[8];
        end
    end

    // Host setting plus what the core reports back
    always_comb begin
        if (bus.offset == CSR_OFF_IRQ)
            bus.rd_data = {4'h0, cfg_interrupt_msienable_i, cfg_interrupt_mmenable_i,
                           cfg_interrupt_do_i, 7'h0, cfg_interrupt_legacyclr_o,
                           cfg_interrupt_di_o};
        else
            bus.rd_data = '0;
    end

endmodule

`default_nettype wire

/* tests/tb_csr_model.svh */
`ifndef TB_CSR_MODEL_SVH
`define TB_CSR_MODEL_SVH

// Host visible state after the most recent edge
logic [31:0] m_r1;         // Level bits 7:5 only
logic [31:0] m_addr;
logic [31:0] m_r3;         // Length, class, flags, upper address
logic [15:0] m_count;
logic [15:0] m_pattern;
logic [8:0]  m_irq;        // Legacy clear and interrupt data
logic [31:0] m_fai;
logic        m_init_rst;
logic        m_start;
logic        m_stop;
logic        m_pend_addr;  // R2 seen since last descriptor
logic        m_pend_ctrl;  // R3 seen since last descriptor

function automatic void model_reset();
    m_r1        = 32'h0;
    m_addr      = 32'h0;
    m_r3        = 32'h0;
    m_count     = 16'h0;
    m_pattern   = 16'h0;
    m_irq       = 9'h0;
    m_fai       = 32'h0;
    m_init_rst  = 1'b0;
    m_start     = 1'b0;
    m_stop      = 1'b0;
    m_pend_addr = 1'b0;
    m_pend_ctrl = 1'b0;
endfunction

// Word the host should see for an index, before this edge's write lands
function automatic logic [31:0] expected_word(input logic [6:0] idx);
    logic [31:0] w;
    w = 32'h0;
    case (idx)
        7'd0:  w = {ID_FAMILY, 4'h0, ID_IFTYPE, ID_VERSION};
        7'd1:  w = m_r1;
        7'd2:  w = m_addr;
        7'd3:  w = m_r3;
        7'd4:  w[15:0] = m_count;
        7'd5:  w[15:0] = m_pattern;
        7'd18: begin
            w[8:0]   = m_irq;
            w[23:16] = cfg_interrupt_do_i;
            w[26:24] = cfg_interrupt_mmenable_i;
            w[27]    = cfg_interrupt_msienable_i;
        end
        7'd32: w = m_fai;
        7'd33: begin
            w[23:8] = wdma_buf_ptr_i;
            w[3:0]  = wdma_status_i;
        end
        7'd34: begin
            w[17:8] = fofb_rxlink_partner_i;
            w[1]    = fofb_cc_timeout_i;
            w[0]    = fofb_rxlink_up_i;
        end
        7'd35: w[15:0] = frameerror_cnt_i;
        7'd36: w[15:0] = softerror_cnt_i;
        7'd37: w[15:0] = harderror_cnt_i;
        default: w = 32'h0;  // Unmapped
    endcase
    return w;
endfunction

// Apply one clock edge of host activity to the model
function automatic void model_edge(input logic [6:0] idx, input logic we,
                                   input logic [31:0] wd);
    logic r1_wr;
    logic done;
    r1_wr   = we && idx == 7'd1;
    done    = m_pend_addr && m_pend_ctrl;  // Strobe was out, flags drop now
    m_start = r1_wr && wd[0] && !m_init_rst;
    m_stop  = r1_wr && wd[1] && !m_init_rst;
    if (done) begin
        m_pend_addr = 1'b0;
        m_pend_ctrl = 1'b0;
    end
    if (we) begin
        case (idx)
            7'd0:  m_init_rst = wd[0];
            7'd1:  m_r1 = wd & 32'h0000_00E0;
            7'd2: begin
                m_addr = wd;
                if (!done)
                    m_pend_addr = 1'b1;
            end
            7'd3: begin
                m_r3 = wd & 32'hFF1F_03FF;
                if (!done)
                    m_pend_ctrl = 1'b1;
            end
            7'd4:  m_count = wd[15:0];
            7'd5:  m_pattern = wd[15:0];
            7'd18: m_irq = wd[8:0];
            7'd32: m_fai = wd;
            default: ;
        endcase
    end
endfunction

`endif

/* tests/tb_csr_top.sv */
`default_nettype none

module tb_csr_top;
    import csr_pkg::*;
    import dma_pkg::*;

    localparam logic [7:0]  ID_FAMILY  = 8'h2A;
    localparam logic [3:0]  ID_IFTYPE  = 4'h5;
    localparam logic [15:0] ID_VERSION = 16'hC3E1;
    localparam csr_addr_t   IDLE_IDX   = 7'd63;  // Outside every block

    localparam int PULSE_START = 0;
    localparam int PULSE_STOP  = 1;
    localparam int PULSE_VALID = 2;

    logic                     clk;
    logic                     init_rst_o;
    csr_addr_t                a_i;
    logic                     wr_en_i;
    csr_word_t                wr_d_i;
    csr_word_t                rd_d_o;
    logic                     initiator_rst_o;
    logic                     mwr_start_o;
    logic                     mwr_stop_o;
    logic                     mwr_relaxed_order_o;
    logic                     mwr_nosnoop_o;
    logic                     mwr_int_dis_o;
    csr_word_t                mwr_addr_o;
    logic [DMA_LEN_W-1:0]     mwr_len_o;
    logic [DMA_TC_W-1:0]      mwr_tlp_tc_o;
    logic                     mwr_64b_en_o;
    logic                     mwr_phant_func_dis1_o;
    logic [DMA_UPADDR_W-1:0]  mwr_up_addr_o;
    logic [DMA_COUNT_W-1:0]   mwr_count_o;
    logic [DMA_PATTERN_W-1:0] mwr_data_o;
    logic                     next_wdma_valid_o;
    logic [7:0]               cfg_interrupt_do_i;
    logic [2:0]               cfg_interrupt_mmenable_i;
    logic                     cfg_interrupt_msienable_i;
    logic [7:0]               cfg_interrupt_di_o;
    logic                     cfg_interrupt_legacyclr_o;
    csr_word_t                fai_cfg_val_o;
    logic [15:0]              wdma_buf_ptr_i;
    logic [3:0]               wdma_status_i;
    logic                     fofb_rxlink_up_i;
    logic                     fofb_cc_timeout_i;
    logic [9:0]               fofb_rxlink_partner_i;
    logic [15:0]              harderror_cnt_i;
    logic [15:0]              softerror_cnt_i;
    logic [15:0]              frameerror_cnt_i;

    csr_word_t exp_rd;
    logic      armed = 1'b0;  // Outputs are defined after the first reset edge

    bmd_csr_top #(
        .FPGA_FAMILY    (ID_FAMILY),
        .INTERFACE_TYPE (ID_IFTYPE),
        .VERSION_NUMBER (ID_VERSION)
    ) dut_i (.*);

    `include "tb_csr_model.svh"

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic stop_on_error(input string why);
        $display("Simulation failed");
        $fatal(1, "%s", why);
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp);
            stop_on_error("output does not match the reference");
        end
    endtask

    // Status inputs from the core change every cycle
    task automatic drive_status();
        cfg_interrupt_do_i        <= 8'($urandom());
        cfg_interrupt_mmenable_i  <= 3'($urandom());
        cfg_interrupt_msienable_i <= 1'($urandom());
        wdma_buf_ptr_i            <= 16'($urandom());
        wdma_status_i             <= 4'($urandom());
        fofb_rxlink_up_i          <= 1'($urandom());
        fofb_cc_timeout_i         <= 1'($urandom());
        fofb_rxlink_partner_i     <= 10'($urandom());
        harderror_cnt_i           <= 16'($urandom());
        softerror_cnt_i           <= 16'($urandom());
        frameerror_cnt_i          <= 16'($urandom());
    endtask

    task automatic bus_write(input csr_addr_t idx, input csr_word_t data);
        @(posedge clk);
        a_i     <= idx;
        wr_en_i <= 1'b1;
        wr_d_i  <= data;
        drive_status();
    endtask

    task automatic bus_read(input csr_addr_t idx);
        @(posedge clk);
        a_i     <= idx;
        wr_en_i <= 1'b0;
        wr_d_i  <= $urandom();  // Ignored without the strobe
        drive_status();
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) bus_read(IDLE_IDX);
    endtask

    // Idle until the chosen output pulses at a falling edge
    task automatic await_pulse(input int which, input int limit);
        int   n;
        logic seen;
        n    = 0;
        seen = 1'b0;
        while (!seen && n < limit) begin
            bus_read(IDLE_IDX);
            @(negedge clk);
            case (which)
                PULSE_START: seen = mwr_start_o;
                PULSE_STOP:  seen = mwr_stop_o;
                default:     seen = next_wdma_valid_o;
            endcase
            n++;
        end
        if (!seen) begin
            $display("Timeout: pulse %0d did not appear within %0d cycles", which, limit);
            stop_on_error("expected pulse never came");
        end
    endtask

    // Compare against the model and then advance it by this edge
    always @(posedge clk) begin
        if (armed) begin
            check_value("rd_d_o", rd_d_o, exp_rd);
            check_value("initiator_rst_o", 32'(initiator_rst_o), 32'(m_init_rst));
            check_value("mwr_start_o", 32'(mwr_start_o), 32'(m_start));
            check_value("mwr_stop_o", 32'(mwr_stop_o), 32'(m_stop));
            check_value("next_wdma_valid_o", 32'(next_wdma_valid_o),
                        32'(m_pend_addr && m_pend_ctrl));
            check_value("R1 level outputs", {24'h0, mwr_int_dis_o, mwr_nosnoop_o,
                        mwr_relaxed_order_o, 5'h0}, m_r1);
            check_value("mwr_addr_o", mwr_addr_o, m_addr);
            check_value("R3 field outputs", {mwr_up_addr_o, 3'h0, mwr_phant_func_dis1_o,
                        mwr_64b_en_o, mwr_tlp_tc_o, 6'h0, mwr_len_o}, m_r3);
            check_value("mwr_count_o", 32'(mwr_count_o), 32'(m_count));
            check_value("mwr_data_o", 32'(mwr_data_o), 32'(m_pattern));
            check_value("interrupt outputs", {23'h0, cfg_interrupt_legacyclr_o,
                        cfg_interrupt_di_o}, {23'h0, m_irq});
            check_value("fai_cfg_val_o", fai_cfg_val_o, m_fai);
        end
        if (init_rst_o) begin
            model_reset();
            exp_rd = 32'h0;
        end else begin
            exp_rd = expected_word(a_i);
            model_edge(a_i, wr_en_i, wr_d_i);
        end
        armed = 1'b1;
    end

    initial begin
        int        i;
        csr_addr_t idx;
        void'($urandom(25992));
        init_rst_o <= 1'b1;
        a_i        <= '0;
        wr_en_i    <= 1'b0;
        wr_d_i     <= '0;
        cfg_interrupt_do_i        <= '0;
        cfg_interrupt_mmenable_i  <= '0;
        cfg_interrupt_msienable_i <= 1'b0;
        wdma_buf_ptr_i            <= '0;
        wdma_status_i             <= '0;
        fofb_rxlink_up_i          <= 1'b0;
        fofb_cc_timeout_i         <= 1'b0;
        fofb_rxlink_partner_i     <= '0;
        harderror_cnt_i           <= '0;
        softerror_cnt_i           <= '0;
        frameerror_cnt_i          <= '0;
        repeat (4) @(posedge clk);
        init_rst_o <= 1'b0;

        // Identification word and cleared registers
        for (i = 0; i < 6; i++)
            bus_read(csr_addr_t'(i));
        bus_read(7'd18);
        bus_read(7'd32);

        // Descriptor strobe for both write orders
        bus_write(7'd2, $urandom());
        idle_cycles(2);
        bus_write(7'd3, $urandom());
        await_pulse(PULSE_VALID, 4);
        bus_write(7'd3, $urandom());
        idle_cycles(3);
        bus_write(7'd2, $urandom());
        await_pulse(PULSE_VALID, 4);
        bus_write(7'd2, $urandom());  // Lone half gives no strobe
        idle_cycles(4);

        // Start and stop pulses and none under initiator reset
        bus_write(7'd1, 32'h1);
        await_pulse(PULSE_START, 4);
        bus_write(7'd1, 32'h2);
        await_pulse(PULSE_STOP, 4);
        bus_write(7'd0, 32'h1);
        bus_write(7'd1, 32'h3);
        idle_cycles(3);
        bus_write(7'd0, 32'h0);
        bus_write(7'd1, 32'hE1);
        await_pulse(PULSE_START, 4);

        // Random DMA register traffic
        for (i = 0; i < 40; i++) begin
            idx = csr_addr_t'(32'd1 + $urandom_range(4, 0));
            bus_write(idx, $urandom());
            bus_read(idx);
        end

        // Interrupt register against changing core status
        for (i = 0; i < 10; i++) begin
            bus_write(7'd18, $urandom());
            bus_read(7'd18);
            bus_read(7'd18);
        end

        // FOFB block and unmapped holes
        for (i = 0; i < 6; i++) begin
            bus_write(7'd32, $urandom());
            for (int k = 32; k < 38; k++)
                bus_read(csr_addr_t'(k));
            bus_write(7'd6, $urandom());
            bus_read(7'd6);
            bus_write(7'd17, $urandom());
            bus_read(7'd17);
            bus_write(7'd19, $urandom());
            bus_read(7'd19);
            bus_write(7'd40, $urandom());
            bus_read(7'd40);
        end

        for (i = 0; i < 30; i++)
            bus_read(csr_addr_t'($urandom_range(63, 0)));
        idle_cycles(2);

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire
